// File: hw/rename_pkg.sv
// Rename stage package with op classes, register widths and default sizes
package rename_pkg;

    // Instruction classes seen by the rename stage
    typedef enum logic [2:0] {
        OP_ALU_REG = 3'd0,
        OP_ALU_IMM = 3'd1,
        OP_LOAD    = 3'd2,
        OP_STORE   = 3'd3,
        OP_BRANCH  = 3'd4
    } rn_op_e;

    // Architectural register file
    // x_i maps to p_i out of reset so the first free register is p32
    parameter int ARCH_REGS = 32;
    parameter int ARCH_W    = 5;

    // Default sizes for the top level
    parameter int PR_ENTRIES_DEF = 64;
    parameter int ROB_DEPTH_DEF  = 8;
    parameter int IQ_DEPTH_DEF   = 4;

    // Ops that write a destination register
    function automatic logic op_has_rd(input rn_op_e op);
        case (op)
            OP_ALU_REG,
            OP_ALU_IMM,
            OP_LOAD:  op_has_rd = 1'b1;
            default:  op_has_rd = 1'b0;
        endcase
    endfunction

    // Ops that read a second source register
    function automatic logic op_uses_rs2(input rn_op_e op);
        case (op)
            OP_ALU_REG,
            OP_STORE,
            OP_BRANCH: op_uses_rs2 = 1'b1;
            default:   op_uses_rs2 = 1'b0;
        endcase
    endfunction

endpackage

// File: hw/instruction_queue.sv
// Instruction queue holding decoded instructions ahead of the dispatcher
`timescale 1ns/1ps

module instruction_queue #(
    parameter int IQ_DEPTH = rename_pkg::IQ_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    // Decoder side
    input  logic                          push,
    input  rename_pkg::rn_op_e            push_op,
    input  logic [31:0]                   push_pc,
    input  logic [rename_pkg::ARCH_W-1:0] push_rs1,
    input  logic [rename_pkg::ARCH_W-1:0] push_rs2,
    input  logic [rename_pkg::ARCH_W-1:0] push_rd,
    // Dispatcher side
    input  logic                          pop,
    output logic                          empty,
    output logic                          full,
    output rename_pkg::rn_op_e            head_op,
    output logic [31:0]                   head_pc,
    output logic [rename_pkg::ARCH_W-1:0] head_rs1,
    output logic [rename_pkg::ARCH_W-1:0] head_rs2,
    output logic [rename_pkg::ARCH_W-1:0] head_rd
);
    import rename_pkg::*;

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    // One array per field
    rn_op_e            op_mem  [IQ_DEPTH];
    logic [31:0]       pc_mem  [IQ_DEPTH];
    logic [ARCH_W-1:0] rs1_mem [IQ_DEPTH];
    logic [ARCH_W-1:0] rs2_mem [IQ_DEPTH];
    logic [ARCH_W-1:0] rd_mem  [IQ_DEPTH];

    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(IQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // A push into a full queue is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(IQ_DEPTH));

    // Head is read straight out of storage
    assign head_op  = op_mem[rd_ptr];
    assign head_pc  = pc_mem[rd_ptr];
    assign head_rs1 = rs1_mem[rd_ptr];
    assign head_rs2 = rs2_mem[rd_ptr];
    assign head_rd  = rd_mem[rd_ptr];

    // Payload written at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            op_mem[wr_ptr]  <= push_op;
            pc_mem[wr_ptr]  <= push_pc;
            rs1_mem[wr_ptr] <= push_rs1;
            rs2_mem[wr_ptr] <= push_rs2;
            rd_mem[wr_ptr]  <= push_rd;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: hw/free_list.sv
// Free list of physical registers kept as a circular FIFO
`timescale 1ns/1ps

module free_list #(
    parameter int PR_ENTRIES = rename_pkg::PR_ENTRIES_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pop,
    input  logic                          push,
    input  logic [$clog2(PR_ENTRIES)-1:0] push_preg,
    output logic                          empty,
    output logic [$clog2(PR_ENTRIES)-1:0] head_preg
);
    import rename_pkg::*;

    localparam int PR_W     = $clog2(PR_ENTRIES);
    // At most this many registers are unmapped at once
    localparam int FL_DEPTH = PR_ENTRIES - ARCH_REGS;
    localparam int PTR_W    = (FL_DEPTH > 1) ? $clog2(FL_DEPTH) : 1;
    localparam int CNT_W    = $clog2(FL_DEPTH + 1);

    logic [PR_W-1:0]  mem [FL_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(FL_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // p0 is the hardwired zero register and never returns to the list
    assign do_push   = push && (push_preg != '0) && (count != CNT_W'(FL_DEPTH));
    assign do_pop    = pop && !empty;
    assign empty     = (count == '0);
    // Oldest free register
    assign head_preg = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Fill with p32 upward in ascending order
            for (int i = 0; i < FL_DEPTH; i++) begin
                mem[i] <= PR_W'(ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= CNT_W'(FL_DEPTH);
        end else begin
            // Freed registers join at the tail
            if (do_push) begin
                mem[wr_ptr] <= push_preg;
                wr_ptr      <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: hw/rename_table.sv
// Register alias table with the busy bits of the physical registers
`timescale 1ns/1ps

module rename_table #(
    parameter int PR_ENTRIES = rename_pkg::PR_ENTRIES_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    // Lookup by architectural number
    input  logic [rename_pkg::ARCH_W-1:0] rs1,
    input  logic [rename_pkg::ARCH_W-1:0] rs2,
    input  logic [rename_pkg::ARCH_W-1:0] rd,
    output logic [$clog2(PR_ENTRIES)-1:0] prs1,
    output logic [$clog2(PR_ENTRIES)-1:0] prs2,
    output logic [$clog2(PR_ENTRIES)-1:0] prd_old,
    output logic                          prs1_busy,
    output logic                          prs2_busy,
    // New mapping for rd
    input  logic                          wr_en,
    input  logic [$clog2(PR_ENTRIES)-1:0] wr_prd,
    // Writeback wakeup
    input  logic                          wb_valid,
    input  logic [$clog2(PR_ENTRIES)-1:0] wb_prd
);
    import rename_pkg::*;

    localparam int PR_W = $clog2(PR_ENTRIES);

    logic [PR_W-1:0]       map [ARCH_REGS];
    logic [PR_ENTRIES-1:0] busy;

    // Current mappings
    assign prs1    = map[rs1];
    assign prs2    = map[rs2];
    assign prd_old = map[rd];

    // Busy unless woken this cycle
    // p0 never waits
    assign prs1_busy = (prs1 != '0) && busy[prs1] && !(wb_valid && (wb_prd == prs1));
    assign prs2_busy = (prs2 != '0) && busy[prs2] && !(wb_valid && (wb_prd == prs2));

    // Alias table
    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping x_i to p_i
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= PR_W'(i);
            end
        end else if (wr_en && (rd != '0)) begin
            // x0 stays on p0
            map[rd] <= wr_prd;
        end
    end

    // Busy table
    always_ff @(posedge clk) begin
        if (rst) begin
            // Everything holds a value out of reset
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_prd] <= 1'b0;
            end
            // New producer wins over a stale wakeup of the same register
            if (wr_en && (wr_prd != '0)) begin
                busy[wr_prd] <= 1'b1;
            end
        end
    end

endmodule

// File: hw/dispatcher.sv
// Dispatcher that renames the queue head and issues one dispatch strobe per cycle
`timescale 1ns/1ps

module dispatcher #(
    parameter int PR_ENTRIES = rename_pkg::PR_ENTRIES_DEF,
    parameter int ROB_DEPTH  = rename_pkg::ROB_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    // Instruction queue head
    input  logic                          iq_empty,
    input  rename_pkg::rn_op_e            iq_op,
    input  logic [31:0]                   iq_pc,
    input  logic [rename_pkg::ARCH_W-1:0] iq_rs1,
    input  logic [rename_pkg::ARCH_W-1:0] iq_rs2,
    input  logic [rename_pkg::ARCH_W-1:0] iq_rd,
    output logic                          iq_pop,
    // Free list
    input  logic                          fl_empty,
    input  logic [$clog2(PR_ENTRIES)-1:0] fl_head,
    output logic                          fl_pop,
    // Rename table lookups and update
    input  logic [$clog2(PR_ENTRIES)-1:0] prs1,
    input  logic [$clog2(PR_ENTRIES)-1:0] prs2,
    input  logic [$clog2(PR_ENTRIES)-1:0] prd_old,
    input  logic                          prs1_busy,
    input  logic                          prs2_busy,
    output logic                          map_wr_en,
    output logic [$clog2(PR_ENTRIES)-1:0] map_wr_prd,
    // Back end status
    input  logic                          rs_full,
    input  logic                          rob_full,
    input  logic                          store_commit,
    // Dispatch entry to the RS and ROB
    output logic                          disp_valid,
    output rename_pkg::rn_op_e            disp_op,
    output logic [31:0]                   disp_pc,
    output logic [$clog2(ROB_DEPTH)-1:0]  disp_rob_id,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prs1,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prs2,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prd,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prd_old,
    output logic                          disp_rs1_ready,
    output logic                          disp_rs2_ready
);
    import rename_pkg::*;

    localparam int PR_W  = $clog2(PR_ENTRIES);
    localparam int ROB_W = $clog2(ROB_DEPTH);

    logic             needs_rd;
    logic             uses_rs2;
    logic             fire;
    logic             store_stall;
    logic             rs1_ready;
    logic             rs2_ready;
    logic [ROB_W-1:0] rob_cnt;

    // Only a real destination takes a register
    assign needs_rd = op_has_rd(iq_op) && (iq_rd != '0);
    assign uses_rs2 = op_uses_rs2(iq_op);

    // Every stall source blocks the head
    assign fire = !iq_empty && !rs_full && !rob_full && !store_stall &&
                  !(needs_rd && fl_empty);

    // Queue pop, free list pop and table write share the edge
    assign iq_pop     = fire;
    assign fl_pop     = fire && needs_rd;
    assign map_wr_en  = fire && needs_rd;
    assign map_wr_prd = fl_head;

    // x0 is always ready
    // Unused rs2 counts as ready
    assign rs1_ready = (iq_rs1 == '0) || !prs1_busy;
    assign rs2_ready = !uses_rs2 || (iq_rs2 == '0) || !prs2_busy;

    // ROB ids in dispatch order
    always_ff @(posedge clk) begin
        if (rst) begin
            rob_cnt <= '0;
        end else if (fire) begin
            rob_cnt <= (rob_cnt == ROB_W'(ROB_DEPTH - 1)) ? '0 : rob_cnt + 1'b1;
        end
    end

    // Store serialization until its commit
    always_ff @(posedge clk) begin
        if (rst) begin
            store_stall <= 1'b0;
        end else if (fire && (iq_op == OP_STORE)) begin
            store_stall <= 1'b1;
        end else if (store_commit) begin
            store_stall <= 1'b0;
        end
    end

    // Strobe one cycle after the rename edge
    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= fire;
        end
    end

    // Entry fields captured with the strobe
    always_ff @(posedge clk) begin
        if (fire) begin
            disp_op        <= iq_op;
            disp_pc        <= iq_pc;
            disp_rob_id    <= rob_cnt;
            disp_prs1      <= prs1;
            disp_prs2      <= prs2;
            // No destination reports p0 for both
            disp_prd       <= needs_rd ? fl_head : PR_W'(0);
            disp_prd_old   <= needs_rd ? prd_old : PR_W'(0);
            disp_rs1_ready <= rs1_ready;
            disp_rs2_ready <= rs2_ready;
        end
    end

endmodule

// File: hw/rename_dispatch_top.sv
// Rename and dispatch stage top joining queue, free list, alias table and dispatcher
`timescale 1ns/1ps

module rename_dispatch_top #(
    parameter int PR_ENTRIES = rename_pkg::PR_ENTRIES_DEF,
    parameter int ROB_DEPTH  = rename_pkg::ROB_DEPTH_DEF,
    parameter int IQ_DEPTH   = rename_pkg::IQ_DEPTH_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    // Decoder push
    input  logic                          in_valid,
    input  rename_pkg::rn_op_e            in_op,
    input  logic [31:0]                   in_pc,
    input  logic [rename_pkg::ARCH_W-1:0] in_rs1,
    input  logic [rename_pkg::ARCH_W-1:0] in_rs2,
    input  logic [rename_pkg::ARCH_W-1:0] in_rd,
    output logic                          iq_full,
    // Feedback from execution and commit
    input  logic                          wb_valid,
    input  logic [$clog2(PR_ENTRIES)-1:0] wb_prd,
    input  logic                          commit_valid,
    input  logic [$clog2(PR_ENTRIES)-1:0] commit_prd_old,
    input  logic                          store_commit,
    input  logic                          rs_full,
    input  logic                          rob_full,
    // Dispatch entry
    output logic                          disp_valid,
    output rename_pkg::rn_op_e            disp_op,
    output logic [31:0]                   disp_pc,
    output logic [$clog2(ROB_DEPTH)-1:0]  disp_rob_id,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prs1,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prs2,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prd,
    output logic [$clog2(PR_ENTRIES)-1:0] disp_prd_old,
    output logic                          disp_rs1_ready,
    output logic                          disp_rs2_ready
);
    import rename_pkg::*;

    localparam int PR_W = $clog2(PR_ENTRIES);

    // Queue head
    logic              iq_empty;
    logic              iq_pop;
    rn_op_e            iq_op;
    logic [31:0]       iq_pc;
    logic [ARCH_W-1:0] iq_rs1;
    logic [ARCH_W-1:0] iq_rs2;
    logic [ARCH_W-1:0] iq_rd;
    // Free list
    logic              fl_empty;
    logic              fl_pop;
    logic [PR_W-1:0]   fl_head;
    // Alias table
    logic [PR_W-1:0]   prs1;
    logic [PR_W-1:0]   prs2;
    logic [PR_W-1:0]   prd_old;
    logic              prs1_busy;
    logic              prs2_busy;
    logic              map_wr_en;
    logic [PR_W-1:0]   map_wr_prd;

    instruction_queue #(.IQ_DEPTH(IQ_DEPTH)) u_iq (
        .clk, .rst,
        .push(in_valid), .push_op(in_op), .push_pc(in_pc),
        .push_rs1(in_rs1), .push_rs2(in_rs2), .push_rd(in_rd),
        .pop(iq_pop), .empty(iq_empty), .full(iq_full),
        .head_op(iq_op), .head_pc(iq_pc),
        .head_rs1(iq_rs1), .head_rs2(iq_rs2), .head_rd(iq_rd)
    );

    // Committed old destinations come back here
    free_list #(.PR_ENTRIES(PR_ENTRIES)) u_fl (
        .clk, .rst,
        .pop(fl_pop), .push(commit_valid), .push_preg(commit_prd_old),
        .empty(fl_empty), .head_preg(fl_head)
    );

    // Looked up with the queue head directly
    rename_table #(.PR_ENTRIES(PR_ENTRIES)) u_rt (
        .clk, .rst,
        .rs1(iq_rs1), .rs2(iq_rs2), .rd(iq_rd),
        .prs1, .prs2, .prd_old, .prs1_busy, .prs2_busy,
        .wr_en(map_wr_en), .wr_prd(map_wr_prd),
        .wb_valid, .wb_prd
    );

    dispatcher #(.PR_ENTRIES(PR_ENTRIES), .ROB_DEPTH(ROB_DEPTH)) u_disp (
        .clk, .rst,
        .iq_empty, .iq_op, .iq_pc, .iq_rs1, .iq_rs2, .iq_rd, .iq_pop,
        .fl_empty, .fl_head, .fl_pop,
        .prs1, .prs2, .prd_old, .prs1_busy, .prs2_busy,
        .map_wr_en, .map_wr_prd,
        .rs_full, .rob_full, .store_commit,
        .disp_valid, .disp_op, .disp_pc, .disp_rob_id,
        .disp_prs1, .disp_prs2, .disp_prd, .disp_prd_old,
        .disp_rs1_ready, .disp_rs2_ready
    );

endmodule

// File: tests/tb_rename_tests.svh
// Directed rename and dispatch tests with their stimulus helpers

// Decoder push that waits while the queue is full
task automatic drive_push(input rn_op_e op, input logic [ARCH_W-1:0] rs1,
                          input logic [ARCH_W-1:0] rs2, input logic [ARCH_W-1:0] rd);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (iq_full) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            abort_run("Timed out waiting for room in the instruction queue");
        end
        @(negedge clk);
    end
    @(posedge clk);
    in_valid <= 1'b1;
    in_op    <= op;
    in_pc    <= next_pc;
    in_rs1   <= rs1;
    in_rs2   <= rs2;
    in_rd    <= rd;
    next_pc  = next_pc + 32'd4;
    @(posedge clk);
    in_valid <= 1'b0;
endtask

task automatic push_instr(input rn_op_e op, input logic [ARCH_W-1:0] rs1,
                          input logic [ARCH_W-1:0] rs2, input logic [ARCH_W-1:0] rd);
    predict(op, rs1, rs2, rd, next_pc);
    drive_push(op, rs1, rs2, rd);
endtask

// Wait until every predicted instruction has dispatched
task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (dispatched != predicted) begin
        @(posedge clk);
        cycles++;
        if (cycles > TIMEOUT) begin
            abort_run("Timed out waiting for outstanding instructions to dispatch");
        end
    end
endtask

// No dispatch since the stall began
task automatic expect_idle(input int start, input int cycles);
    repeat (cycles) @(posedge clk);
    if (dispatched != start) begin
        abort_run("An instruction dispatched while the stage should be stalled");
    end
endtask

// Queue occupancy flag seen by the decoder
task automatic check_full(input logic exp);
    @(negedge clk);
    check_bit("iq_full", iq_full, exp);
endtask

task automatic pulse_wb(input logic [PR_W-1:0] prd);
    @(posedge clk);
    wb_valid <= 1'b1;
    wb_prd   <= prd;
    ref_busy[prd] = 1'b0;
    @(posedge clk);
    wb_valid <= 1'b0;
endtask

task automatic pulse_commit(input logic [PR_W-1:0] prd_old);
    @(posedge clk);
    commit_valid   <= 1'b1;
    commit_prd_old <= prd_old;
    // p0 never returns to the free list
    if (prd_old != '0) begin
        ref_free.push_back(prd_old);
    end
    @(posedge clk);
    commit_valid <= 1'b0;
endtask

task automatic pulse_store_commit();
    @(posedge clk);
    store_commit <= 1'b1;
    @(posedge clk);
    store_commit <= 1'b0;
endtask

task automatic set_stalls(input logic rs, input logic rob);
    @(posedge clk);
    rs_full  <= rs;
    rob_full <= rob;
endtask

// First op out of reset reads identity mappings and takes p32
task automatic test_first_dispatch();
    push_instr(OP_ALU_REG, 5'd5, 5'd9, 5'd1);
    wait_drain();
endtask

// Back-to-back random ops with one of them writing x0
task automatic test_random_chain();
    rn_op_e op;
    for (int i = 0; i < 12; i++) begin
        op = (i % 3 == 0) ? OP_ALU_REG : ((i % 3 == 1) ? OP_ALU_IMM : OP_LOAD);
        push_instr(op, pick_reg(0), pick_reg(0), (i == 5) ? 5'd0 : pick_reg(0));
    end
    wait_drain();
endtask

task automatic test_wakeup();
    logic [PR_W-1:0] producer;
    push_instr(OP_ALU_REG, 5'd1, 5'd2, 5'd7);
    wait_drain();
    producer = last_prd;
    // x7 still in flight
    push_instr(OP_ALU_REG, 5'd7, 5'd0, 5'd0);
    // Immediate form ignores rs2
    push_instr(OP_ALU_IMM, 5'd0, 5'd7, 5'd0);
    wait_drain();
    pulse_wb(producer);
    push_instr(OP_BRANCH, 5'd7, 5'd7, 5'd0);
    wait_drain();
endtask

// Fill the queue under each back end stall and then release
task automatic test_backend_stall();
    int start;
    for (int pass = 0; pass < 2; pass++) begin
        set_stalls(pass == 0, pass == 1);
        start = dispatched;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            push_instr(OP_ALU_REG, pick_reg(0), pick_reg(0), pick_reg(0));
        end
        expect_idle(start, 8);
        // Every held instruction still sits in the queue
        check_full(1'b1);
        set_stalls(1'b0, 1'b0);
        wait_drain();
        check_full(1'b0);
    end
endtask

task automatic test_store_serialize();
    int start;
    push_instr(OP_STORE, 5'd3, 5'd4, 5'd0);
    wait_drain();
    start = dispatched;
    push_instr(OP_ALU_IMM, 5'd3, 5'd0, 5'd8);
    push_instr(OP_LOAD, 5'd8, 5'd0, 5'd9);
    expect_idle(start, 6);
    pulse_store_commit();
    wait_drain();
endtask

task automatic test_free_list_drain();
    logic [PR_W-1:0] freed;
    logic [31:0]     held_pc;
    int              start;
    while (ref_free.size() > 1) begin
        push_instr(OP_ALU_IMM, pick_reg(0), 5'd0, pick_reg(1));
        wait_drain();
    end
    // Freed register queues behind the last original entry
    pulse_commit(last_prd_old);
    push_instr(OP_LOAD, 5'd2, 5'd0, 5'd3);
    push_instr(OP_LOAD, 5'd2, 5'd0, 5'd4);
    wait_drain();
    if (ref_free.size() != 0) begin
        abort_run("Free list should be empty after the drain sequence");
    end
    // Next rd writer stalls until a commit frees a register
    freed   = last_prd_old;
    held_pc = next_pc;
    start   = dispatched;
    drive_push(OP_ALU_REG, 5'd1, 5'd2, 5'd6);
    expect_idle(start, 8);
    pulse_commit(freed);
    predict(OP_ALU_REG, 5'd1, 5'd2, 5'd6, held_pc);
    wait_drain();
endtask

task automatic run_all();
    test_first_dispatch();
    test_random_chain();
    test_wakeup();
    test_backend_stall();
    test_store_serialize();
    test_free_list_drain();
endtask

// File: tests/tb_rename_dispatch.sv
// Testbench for the rename and dispatch stage with a reference rename model
`timescale 1ns/1ps

module tb_rename_dispatch;
    import rename_pkg::*;

    localparam int PR_ENTRIES = PR_ENTRIES_DEF;
    localparam int ROB_DEPTH  = ROB_DEPTH_DEF;
    localparam int IQ_DEPTH   = IQ_DEPTH_DEF;
    localparam int PR_W       = $clog2(PR_ENTRIES);
    localparam int ROB_W      = $clog2(ROB_DEPTH);
    localparam int TIMEOUT    = 200;

    // One predicted dispatch entry
    typedef struct packed {
        rn_op_e           op;
        logic [31:0]      pc;
        logic [ROB_W-1:0] rob_id;
        logic [PR_W-1:0]  prs1;
        logic [PR_W-1:0]  prs2;
        logic [PR_W-1:0]  prd;
        logic [PR_W-1:0]  prd_old;
        logic             rs1_ready;
        logic             rs2_ready;
    } entry_t;

    logic              clk;
    logic              rst;
    logic              in_valid;
    rn_op_e            in_op;
    logic [31:0]       in_pc;
    logic [ARCH_W-1:0] in_rs1;
    logic [ARCH_W-1:0] in_rs2;
    logic [ARCH_W-1:0] in_rd;
    logic              iq_full;
    logic              wb_valid;
    logic [PR_W-1:0]   wb_prd;
    logic              commit_valid;
    logic [PR_W-1:0]   commit_prd_old;
    logic              store_commit;
    logic              rs_full;
    logic              rob_full;
    logic              disp_valid;
    rn_op_e            disp_op;
    logic [31:0]       disp_pc;
    logic [ROB_W-1:0]  disp_rob_id;
    logic [PR_W-1:0]   disp_prs1;
    logic [PR_W-1:0]   disp_prs2;
    logic [PR_W-1:0]   disp_prd;
    logic [PR_W-1:0]   disp_prd_old;
    logic              disp_rs1_ready;
    logic              disp_rs2_ready;

    // Reference state
    logic [PR_W-1:0]       ref_map [ARCH_REGS];
    logic [PR_ENTRIES-1:0] ref_busy;
    logic [PR_W-1:0]       ref_free [$];
    logic [ROB_W-1:0]      ref_rob;
    entry_t                exp_q [$];
    logic [31:0]           next_pc;
    logic [PR_W-1:0]       last_prd;
    logic [PR_W-1:0]       last_prd_old;
    int                    predicted;
    int                    dispatched;
    int unsigned           seed_ret;

    rename_dispatch_top #(
        .PR_ENTRIES(PR_ENTRIES),
        .ROB_DEPTH(ROB_DEPTH),
        .IQ_DEPTH(IQ_DEPTH)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_op(input string name, input rn_op_e got, input rn_op_e exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=%s expected=%s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_preg(input string name, input logic [PR_W-1:0] got,
                              input logic [PR_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_rob_id(input string name, input logic [ROB_W-1:0] got,
                                input logic [ROB_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                                $time, name, got, exp));
        end
    endtask

    // Op classes as the stage rules define them
    function automatic logic writes_dest(input rn_op_e op);
        return (op == OP_ALU_REG) || (op == OP_ALU_IMM) || (op == OP_LOAD);
    endfunction

    function automatic logic reads_rs2(input rn_op_e op);
        return (op == OP_ALU_REG) || (op == OP_STORE) || (op == OP_BRANCH);
    endfunction

    function automatic logic [ARCH_W-1:0] pick_reg(input int low);
        return ARCH_W'($urandom_range(ARCH_REGS - 1, low));
    endfunction

    // Identity map, nothing busy, p32 upward free
    task automatic init_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            ref_map[i] = PR_W'(i);
        end
        ref_busy = '0;
        ref_free.delete();
        for (int i = ARCH_REGS; i < PR_ENTRIES; i++) begin
            ref_free.push_back(PR_W'(i));
        end
        ref_rob = '0;
    endtask

    // Rename one instruction in program order
    task automatic predict(input rn_op_e op, input logic [ARCH_W-1:0] rs1,
                           input logic [ARCH_W-1:0] rs2, input logic [ARCH_W-1:0] rd,
                           input logic [31:0] pc);
        entry_t e;
        e.op        = op;
        e.pc        = pc;
        e.rob_id    = ref_rob;
        e.prs1      = ref_map[rs1];
        e.prs2      = ref_map[rs2];
        e.rs1_ready = (e.prs1 == '0) || !ref_busy[e.prs1];
        e.rs2_ready = !reads_rs2(op) || (e.prs2 == '0) || !ref_busy[e.prs2];
        e.prd       = '0;
        e.prd_old   = '0;
        if (writes_dest(op) && (rd != '0)) begin
            if (ref_free.size() == 0) begin
                abort_run("Reference free list ran out while predicting a rename");
            end else begin
                e.prd       = ref_free.pop_front();
                e.prd_old   = ref_map[rd];
                ref_map[rd] = e.prd;
                ref_busy[e.prd] = 1'b1;
            end
        end
        // ROB ids count modulo the ROB depth
        ref_rob      = ROB_W'((int'(ref_rob) + 1) % ROB_DEPTH);
        last_prd     = e.prd;
        last_prd_old = e.prd_old;
        exp_q.push_back(e);
        predicted++;
    endtask

    // Every strobe is matched against the oldest prediction
    task automatic compare_entry();
        entry_t e;
        if (exp_q.size() == 0) begin
            abort_run($sformatf("Dispatch at %0t ns with no instruction outstanding", $time));
        end else begin
            e = exp_q.pop_front();
            check_op("disp_op", disp_op, e.op);
            check_pc("disp_pc", disp_pc, e.pc);
            check_rob_id("disp_rob_id", disp_rob_id, e.rob_id);
            check_preg("disp_prs1", disp_prs1, e.prs1);
            check_preg("disp_prs2", disp_prs2, e.prs2);
            check_preg("disp_prd", disp_prd, e.prd);
            check_preg("disp_prd_old", disp_prd_old, e.prd_old);
            check_bit("disp_rs1_ready", disp_rs1_ready, e.rs1_ready);
            check_bit("disp_rs2_ready", disp_rs2_ready, e.rs2_ready);
        end
    endtask

    // Outputs sampled half a cycle after the edge
    always @(negedge clk) begin
        if (!rst && (disp_valid === 1'b1)) begin
            compare_entry();
            dispatched++;
        end
    end

    `include "tb_rename_tests.svh"

    initial begin
        rst            = 1'b1;
        in_valid       = 1'b0;
        in_op          = OP_ALU_REG;
        in_pc          = '0;
        in_rs1         = '0;
        in_rs2         = '0;
        in_rd          = '0;
        wb_valid       = 1'b0;
        wb_prd         = '0;
        commit_valid   = 1'b0;
        commit_prd_old = '0;
        store_commit   = 1'b0;
        rs_full        = 1'b0;
        rob_full       = 1'b0;
        next_pc        = 32'h0000_1000;
        predicted      = 0;
        dispatched     = 0;
        seed_ret       = $urandom(32'heb29_7902);
        init_model();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        run_all();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: sources.f
+incdir+tests
hw/rename_pkg.sv
hw/instruction_queue.sv
hw/free_list.sv
hw/rename_table.sv
hw/dispatcher.sv
hw/rename_dispatch_top.sv
tests/tb_rename_dispatch.sv
